// ==== gfx_fb_pkg.sv ====
package gfx_fb_pkg;

  // Coordinate and colour widths of the pixel stream.
  localparam int unsigned H_WIDTH = 12;
  localparam int unsigned V_WIDTH = 12;
  localparam int unsigned PIXEL_WIDTH = 12;

  // AXI4 write bus widths.
  localparam int unsigned AXI_ADDR_WIDTH = 20;
  localparam int unsigned AXI_DATA_WIDTH = 16;
  localparam int unsigned AXI_ID_WIDTH = 4;

  // Pixel index to byte address scaling, log2 of the bytes per data word.
  localparam int unsigned WORD_SHIFT = $clog2(AXI_DATA_WIDTH / 8);

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // One pixel command from the upstream renderer.
  typedef struct packed {
    logic [H_WIDTH-1:0]     x;
    logic [V_WIDTH-1:0]     y;
    logic [PIXEL_WIDTH-1:0] pixel;
  } gfx_pix_t;

  // One AW request.
  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_ID_WIDTH-1:0]   id;
  } fb_aw_t;

  // One W beat. Strobe and last are constant and are made at the port.
  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
  } fb_w_t;

  // A clipped pixel with its byte address, ready for the write master.
  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_DATA_WIDTH-1:0] data;
  } fb_cmd_t;

endpackage

// ==== gfx_fb_fifo.sv ====
`timescale 1ns/1ps

module gfx_fb_fifo #(
  parameter type T = logic [7:0],
  parameter int unsigned DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push;
  logic             pop;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  assign count_next = count + CNT_W'(push) - CNT_W'(pop);

  // The head entry comes straight out of the storage array.
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      // Ready is registered, so it looks one cycle ahead at the fill level.
      in_ready <= (count_next != CNT_W'(DEPTH));
    end
  end

  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> count < CNT_W'(DEPTH)
  ) else $error("FIFO written while full");

  // A read from an empty FIFO would wrap the count past DEPTH.
  a_count_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(DEPTH)
  ) else $error("FIFO count out of range, read while empty");

endmodule

// ==== gfx_fb_addr.sv ====
`timescale 1ns/1ps

module gfx_fb_addr (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [gfx_fb_pkg::H_WIDTH-1:0]        h_visible,
  input  logic [gfx_fb_pkg::V_WIDTH-1:0]        v_visible,
  input  logic [gfx_fb_pkg::AXI_ADDR_WIDTH-1:0] fb_base,
  input  logic                                  pix_valid,
  output logic                                  pix_ready,
  input  gfx_fb_pkg::gfx_pix_t                  pix,
  output logic                                  cmd_valid,
  input  logic                                  cmd_ready,
  output gfx_fb_pkg::fb_cmd_t                   cmd
);

  import gfx_fb_pkg::*;

  logic [H_WIDTH+V_WIDTH-1:0] row_off;
  logic [H_WIDTH+V_WIDTH:0]   pix_index;
  logic [AXI_ADDR_WIDTH-1:0]  byte_off;
  logic                       in_range;
  logic                       take;
  fb_cmd_t                    cmd_next;

  assign in_range = (pix.x < h_visible) && (pix.y < v_visible);

  // Row-major layout: one row is h_visible words long.
  assign row_off   = pix.y * h_visible;
  assign pix_index = row_off + pix.x;
  assign byte_off  = AXI_ADDR_WIDTH'(pix_index << WORD_SHIFT);

  assign cmd_next.addr = fb_base + byte_off;
  assign cmd_next.data = AXI_DATA_WIDTH'(pix.pixel);

  // The output register is free when empty or when its entry leaves this cycle.
  assign pix_ready = !cmd_valid || cmd_ready;
  assign take      = pix_valid && pix_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
    end else if (take) begin
      // Clipped pixels are popped but leave the register empty.
      cmd_valid <= in_range;
    end else if (cmd_ready) begin
      cmd_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take && in_range) begin
      cmd <= cmd_next;
    end
  end

  a_cmd_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd)
  ) else $error("Command changed while stalled");

endmodule

// ==== gfx_fb_axi_wr.sv ====
`timescale 1ns/1ps

module gfx_fb_axi_wr #(
  parameter int unsigned MAX_OUTSTANDING = 8,
  parameter int unsigned W_DEPTH = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,

  input  logic                                    cmd_valid,
  output logic                                    cmd_ready,
  input  gfx_fb_pkg::fb_cmd_t                     cmd,

  output logic                                    m_axi_awvalid,
  input  logic                                    m_axi_awready,
  output gfx_fb_pkg::fb_aw_t                      m_axi_aw,
  output logic [7:0]                              m_axi_awlen,
  output logic [2:0]                              m_axi_awsize,
  output logic [1:0]                              m_axi_awburst,

  output logic                                    m_axi_wvalid,
  input  logic                                    m_axi_wready,
  output logic [gfx_fb_pkg::AXI_DATA_WIDTH-1:0]   m_axi_wdata,
  output logic [gfx_fb_pkg::AXI_DATA_WIDTH/8-1:0] m_axi_wstrb,
  output logic                                    m_axi_wlast,

  input  logic                                    m_axi_bvalid,
  output logic                                    m_axi_bready,
  input  logic [gfx_fb_pkg::AXI_ID_WIDTH-1:0]     m_axi_bid,
  input  logic [1:0]                              m_axi_bresp,

  output logic [7:0]                              err_count
);

  import gfx_fb_pkg::*;

  localparam int unsigned OST_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned N_IDS = 2 ** AXI_ID_WIDTH;

  logic [OST_W-1:0]        outstanding;
  logic [AXI_ID_WIDTH-1:0] next_id;
  logic [N_IDS-1:0]        id_pending;
  logic                    aw_free;
  logic                    w_free;
  logic                    slot_free;
  logic                    accept;
  logic                    b_hs;
  fb_w_t                   w_in;
  fb_w_t                   w_out;

  // Single-beat incrementing writes of one full data word.
  assign m_axi_awlen   = 8'd0;
  assign m_axi_awsize  = 3'(WORD_SHIFT);
  assign m_axi_awburst = AXI_BURST_INCR;
  assign m_axi_wstrb   = '1;
  assign m_axi_wlast   = 1'b1;

  assign aw_free   = !m_axi_awvalid || m_axi_awready;
  assign slot_free = (outstanding < OST_W'(MAX_OUTSTANDING));
  assign cmd_ready = slot_free && w_free && aw_free;
  assign accept    = cmd_valid && cmd_ready;
  assign b_hs      = m_axi_bvalid && m_axi_bready;

  // AW register. The W beat goes to its own FIFO in the same cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_axi_awvalid <= 1'b0;
      next_id       <= '0;
    end else if (accept) begin
      m_axi_awvalid <= 1'b1;
      next_id       <= next_id + 1'b1;
    end else if (m_axi_awready) begin
      m_axi_awvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      m_axi_aw.addr <= cmd.addr;
      m_axi_aw.id   <= next_id;
    end
  end

  assign w_in.data   = cmd.data;
  assign m_axi_wdata = w_out.data;

  gfx_fb_fifo #(
    .T     (fb_w_t),
    .DEPTH (W_DEPTH)
  ) i_w_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (accept),
    .in_ready  (w_free),
    .in_data   (w_in),
    .out_valid (m_axi_wvalid),
    .out_ready (m_axi_wready),
    .out_data  (w_out)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      outstanding  <= '0;
      m_axi_bready <= 1'b0;
      err_count    <= '0;
    end else begin
      m_axi_bready <= 1'b1;
      if (accept && !b_hs) begin
        outstanding <= outstanding + 1'b1;
      end else if (b_hs && !accept) begin
        outstanding <= outstanding - 1'b1;
      end
      if (b_hs && (m_axi_bresp != AXI_RESP_OKAY) && (err_count != 8'hff)) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

  // IDs of writes that still wait for their response.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_pending <= '0;
    end else begin
      id_pending <= (id_pending | (N_IDS'(accept) << next_id))
                  & ~(N_IDS'(b_hs) << m_axi_bid);
    end
  end

  a_ost_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    outstanding <= OST_W'(MAX_OUTSTANDING)
  ) else $error("Outstanding writes above limit");

  a_aw_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_aw)
  ) else $error("AW request changed before awready");

  a_bid_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    b_hs |-> id_pending[m_axi_bid]
  ) else $error("B response for an ID with no write in flight");

endmodule

// ==== gfx_fb.sv ====
`timescale 1ns/1ps

module gfx_fb #(
  parameter int unsigned IN_DEPTH = 4,
  parameter int unsigned MAX_OUTSTANDING = 8,
  parameter int unsigned W_DEPTH = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,

  input  logic                                    s_gfx_valid,
  output logic                                    s_gfx_ready,
  input  gfx_fb_pkg::gfx_pix_t                    s_gfx,

  input  logic [gfx_fb_pkg::H_WIDTH-1:0]          h_visible,
  input  logic [gfx_fb_pkg::V_WIDTH-1:0]          v_visible,
  input  logic [gfx_fb_pkg::AXI_ADDR_WIDTH-1:0]   fb_base,

  output logic                                    m_axi_awvalid,
  input  logic                                    m_axi_awready,
  output gfx_fb_pkg::fb_aw_t                      m_axi_aw,
  output logic [7:0]                              m_axi_awlen,
  output logic [2:0]                              m_axi_awsize,
  output logic [1:0]                              m_axi_awburst,

  output logic                                    m_axi_wvalid,
  input  logic                                    m_axi_wready,
  output logic [gfx_fb_pkg::AXI_DATA_WIDTH-1:0]   m_axi_wdata,
  output logic [gfx_fb_pkg::AXI_DATA_WIDTH/8-1:0] m_axi_wstrb,
  output logic                                    m_axi_wlast,

  input  logic                                    m_axi_bvalid,
  output logic                                    m_axi_bready,
  input  logic [gfx_fb_pkg::AXI_ID_WIDTH-1:0]     m_axi_bid,
  input  logic [1:0]                              m_axi_bresp,

  output logic [7:0]                              err_count
);

  import gfx_fb_pkg::*;

  logic     pix_valid;
  logic     pix_ready;
  gfx_pix_t pix;
  logic     cmd_valid;
  logic     cmd_ready;
  fb_cmd_t  cmd;

  gfx_fb_fifo #(
    .T     (gfx_pix_t),
    .DEPTH (IN_DEPTH)
  ) i_in_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s_gfx_valid),
    .in_ready  (s_gfx_ready),
    .in_data   (s_gfx),
    .out_valid (pix_valid),
    .out_ready (pix_ready),
    .out_data  (pix)
  );

  gfx_fb_addr i_addr (
    .clk       (clk),
    .rst_n     (rst_n),
    .h_visible (h_visible),
    .v_visible (v_visible),
    .fb_base   (fb_base),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .pix       (pix),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd)
  );

  gfx_fb_axi_wr #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING),
    .W_DEPTH         (W_DEPTH)
  ) i_axi_wr (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd           (cmd),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_aw      (m_axi_aw),
    .m_axi_awlen   (m_axi_awlen),
    .m_axi_awsize  (m_axi_awsize),
    .m_axi_awburst (m_axi_awburst),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready),
    .m_axi_bid     (m_axi_bid),
    .m_axi_bresp   (m_axi_bresp),
    .err_count     (err_count)
  );

endmodule

// ==== gfx_fb_tb.sv ====
`timescale 1ns/1ps

module gfx_fb_tb;

  import gfx_fb_pkg::*;

  localparam int unsigned N_ROWS = 24;
  localparam int unsigned LIMIT = 400;
  localparam logic [AXI_ADDR_WIDTH-1:0] FB_BASE = 20'h10000;

  typedef struct packed {
    logic [H_WIDTH-1:0]     x;
    logic [V_WIDTH-1:0]     y;
    logic [PIXEL_WIDTH-1:0] pixel;
    logic [H_WIDTH-1:0]     h;
    logic [V_WIDTH-1:0]     v;
    logic                   inject;
  } row_t;

  logic                          clk;
  logic                          rst_n;
  logic                          s_gfx_valid;
  logic                          s_gfx_ready;
  gfx_pix_t                      s_gfx;
  logic [H_WIDTH-1:0]            h_visible;
  logic [V_WIDTH-1:0]            v_visible;
  logic [AXI_ADDR_WIDTH-1:0]     fb_base;
  logic                          m_axi_awvalid;
  logic                          m_axi_awready;
  fb_aw_t                        m_axi_aw;
  logic [7:0]                    m_axi_awlen;
  logic [2:0]                    m_axi_awsize;
  logic [1:0]                    m_axi_awburst;
  logic                          m_axi_wvalid;
  logic                          m_axi_wready;
  logic [AXI_DATA_WIDTH-1:0]     m_axi_wdata;
  logic [AXI_DATA_WIDTH/8-1:0]   m_axi_wstrb;
  logic                          m_axi_wlast;
  logic                          m_axi_bvalid;
  logic                          m_axi_bready;
  logic [AXI_ID_WIDTH-1:0]       m_axi_bid;
  logic [1:0]                    m_axi_bresp;
  logic [7:0]                    err_count;

  row_t                          rows [N_ROWS];
  bit                            row_in [N_ROWS];
  fb_aw_t                        exp_aw [$];
  logic [AXI_DATA_WIDTH-1:0]     exp_data [$];
  bit                            exp_err [$];
  int                            checks;
  int                            errors;
  int                            aw_count;
  int                            w_count;
  int                            b_count;

  gfx_fb #(
    .IN_DEPTH        (4),
    .MAX_OUTSTANDING (4),
    .W_DEPTH         (2)
  ) i_gfx_fb (
    .clk (clk), .rst_n (rst_n),
    .s_gfx_valid (s_gfx_valid), .s_gfx_ready (s_gfx_ready), .s_gfx (s_gfx),
    .h_visible (h_visible), .v_visible (v_visible), .fb_base (fb_base),
    .m_axi_awvalid (m_axi_awvalid), .m_axi_awready (m_axi_awready), .m_axi_aw (m_axi_aw),
    .m_axi_awlen (m_axi_awlen), .m_axi_awsize (m_axi_awsize), .m_axi_awburst (m_axi_awburst),
    .m_axi_wvalid (m_axi_wvalid), .m_axi_wready (m_axi_wready), .m_axi_wdata (m_axi_wdata),
    .m_axi_wstrb (m_axi_wstrb), .m_axi_wlast (m_axi_wlast),
    .m_axi_bvalid (m_axi_bvalid), .m_axi_bready (m_axi_bready), .m_axi_bid (m_axi_bid),
    .m_axi_bresp (m_axi_bresp), .err_count (err_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_aw(input string name, input fb_aw_t exp, input fb_aw_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected addr=%h id=%h actual addr=%h id=%h",
               name, exp.addr, exp.id, act.addr, act.id);
    end
  endtask

  task automatic check_data(input string name, input logic [AXI_DATA_WIDTH-1:0] exp,
                            input logic [AXI_DATA_WIDTH-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Each group of rows shares one visible area and ends with an in-range pixel.
  task automatic load_table();
    rows[0]  = '{12'd0,    12'd0,    12'h123, 12'd320, 12'd240, 1'b0};
    rows[1]  = '{12'd319,  12'd0,    12'habc, 12'd320, 12'd240, 1'b0};
    rows[2]  = '{12'd5,    12'd1,    12'h001, 12'd320, 12'd240, 1'b1};
    rows[3]  = '{12'd320,  12'd3,    12'h777, 12'd320, 12'd240, 1'b0};
    rows[4]  = '{12'd10,   12'd239,  12'hfff, 12'd320, 12'd240, 1'b0};
    rows[5]  = '{12'd7,    12'd240,  12'h555, 12'd320, 12'd240, 1'b0};
    rows[6]  = '{12'd100,  12'd100,  12'h0f0, 12'd320, 12'd240, 1'b0};
    rows[7]  = '{12'd319,  12'd239,  12'h3c3, 12'd320, 12'd240, 1'b1};
    rows[8]  = '{12'd0,    12'd0,    12'h800, 12'd64,  12'd48,  1'b0};
    rows[9]  = '{12'd63,   12'd47,   12'h7ff, 12'd64,  12'd48,  1'b0};
    rows[10] = '{12'd64,   12'd48,   12'h111, 12'd64,  12'd48,  1'b0};
    rows[11] = '{12'd1,    12'd2,    12'h222, 12'd64,  12'd48,  1'b1};
    rows[12] = '{12'd33,   12'd12,   12'h333, 12'd64,  12'd48,  1'b0};
    rows[13] = '{12'd40,   12'd30,   12'h444, 12'd64,  12'd48,  1'b0};
    rows[14] = '{12'd2,    12'd47,   12'h999, 12'd64,  12'd48,  1'b0};
    rows[15] = '{12'd639,  12'd7,    12'ha5a, 12'd640, 12'd8,   1'b0};
    rows[16] = '{12'd0,    12'd8,    12'h5a5, 12'd640, 12'd8,   1'b1};
    rows[17] = '{12'd200,  12'd3,    12'h246, 12'd640, 12'd8,   1'b0};
    rows[18] = '{12'd400,  12'd5,    12'h468, 12'd640, 12'd8,   1'b1};
    rows[19] = '{12'd12,   12'd0,    12'h68a, 12'd640, 12'd8,   1'b0};
    rows[20] = '{12'd639,  12'd0,    12'heee, 12'd640, 12'd8,   1'b0};
    rows[21] = '{12'd4095, 12'd4095, 12'h000, 12'd640, 12'd8,   1'b0};
    rows[22] = '{12'd1,    12'd1,    12'hcdc, 12'd640, 12'd8,   1'b0};
    rows[23] = '{12'd600,  12'd6,    12'hbeb, 12'd640, 12'd8,   1'b0};
  endtask

  function automatic logic [AXI_ADDR_WIDTH-1:0] pixel_addr(input int x, input int y,
                                                           input int h);
    int index;
    index = y * h + x;
    return FB_BASE + AXI_ADDR_WIDTH'(index << 1);
  endfunction

  task automatic send_pixel(input int r);
    bit accepted;
    s_gfx_valid = 1'b1;
    s_gfx = '{rows[r].x, rows[r].y, rows[r].pixel};
    accepted = 1'b0;
    for (int t = 0; t < LIMIT && !accepted; t++) begin
      @(posedge clk);
      accepted = s_gfx_ready;
    end
    #1;
    s_gfx_valid = 1'b0;
    if (!accepted) begin
      errors++;
      $display("Pixel of row %0d was never accepted by the DUT", r);
    end
  endtask

  task automatic wait_writes(input int n_aw, input int n_b);
    bit done;
    done = 1'b0;
    for (int t = 0; t < LIMIT * 4 && !done; t++) begin
      @(posedge clk);
      #1;
      done = (aw_count >= n_aw) && (w_count >= n_aw) && (b_count >= n_b);
    end
    if (!done) begin
      errors++;
      $display("Timed out waiting for %0d writes, saw %0d AW and %0d W", n_aw, aw_count, w_count);
    end
  endtask

  // AXI memory model with random ready and response delays.
  initial begin : axi_slave
    logic [AXI_ID_WIDTH-1:0] b_id_q [$];
    bit                      b_err_q [$];
    int                      b_wait;
    int                      b_hold;
    bit                      b_done;
    void'($urandom(32'h536e));
    b_wait = 0;
    b_hold = 0;
    forever begin
      @(posedge clk);
      b_done = 1'b0;
      if (rst_n) begin
        if (m_axi_awvalid && m_axi_awready) begin
          if (aw_count < exp_aw.size()) begin
            check_aw($sformatf("aw %0d", aw_count), exp_aw[aw_count], m_axi_aw);
            b_err_q.push_back(exp_err[aw_count]);
          end else begin
            errors++;
            $display("Extra AW request to address %h", m_axi_aw.addr);
            b_err_q.push_back(1'b0);
          end
          check_count("awlen", 8'd0, m_axi_awlen);
          check_count("awsize", 8'd1, 8'(m_axi_awsize));
          check_count("awburst", 8'd1, 8'(m_axi_awburst));
          b_id_q.push_back(m_axi_aw.id);
          aw_count++;
        end
        if (m_axi_wvalid && m_axi_wready) begin
          if (w_count < exp_data.size()) begin
            check_data($sformatf("w %0d", w_count), exp_data[w_count], m_axi_wdata);
          end else begin
            errors++;
            $display("Extra W beat with data %h", m_axi_wdata);
          end
          check_count("wstrb", 8'h03, 8'(m_axi_wstrb));
          check_count("wlast", 8'd1, 8'(m_axi_wlast));
          w_count++;
        end
        if (m_axi_bvalid && m_axi_bready) begin
          b_count++;
          b_done = 1'b1;
        end else if (m_axi_bvalid) begin
          b_hold++;
          if (b_hold > LIMIT) begin
            errors++;
            $display("B response never accepted, bready stayed low");
            b_done = 1'b1;
          end
        end
      end
      #1;
      m_axi_awready = ($urandom_range(3) != 0);
      m_axi_wready  = ($urandom_range(3) != 0);
      if (b_done) begin
        m_axi_bvalid = 1'b0;
        b_hold = 0;
      end
      if (!m_axi_bvalid && b_id_q.size() > 0) begin
        if (b_wait == 0) begin
          m_axi_bvalid = 1'b1;
          m_axi_bid    = b_id_q.pop_front();
          m_axi_bresp  = b_err_q.pop_front() ? 2'b10 : AXI_RESP_OKAY;
          b_wait       = $urandom_range(3);
        end else begin
          b_wait--;
        end
      end
    end
  end

  initial begin : main
    int     n_in;
    int     n_err;
    bit     ready_seen;
    fb_aw_t aw_exp;
    rst_n         = 1'b0;
    s_gfx_valid   = 1'b0;
    s_gfx         = '0;
    fb_base       = FB_BASE;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    m_axi_bid     = '0;
    m_axi_bresp   = AXI_RESP_OKAY;
    checks = 0;
    errors = 0;
    n_in   = 0;
    n_err  = 0;
    load_table();
    h_visible = rows[0].h;
    v_visible = rows[0].v;
    for (int r = 0; r < N_ROWS; r++) begin
      row_in[r] = (rows[r].x < rows[r].h) && (rows[r].y < rows[r].v);
      if (row_in[r]) begin
        aw_exp.addr = pixel_addr(rows[r].x, rows[r].y, rows[r].h);
        aw_exp.id   = AXI_ID_WIDTH'(exp_aw.size() % 16);
        exp_aw.push_back(aw_exp);
        exp_data.push_back(AXI_DATA_WIDTH'(rows[r].pixel));
        exp_err.push_back(rows[r].inject);
        n_err += rows[r].inject;
      end
    end
    repeat (3) @(posedge clk);
    check_count("s_gfx_ready in reset", 8'd0, 8'(s_gfx_ready));
    #1;
    rst_n = 1'b1;
    ready_seen = 1'b0;
    for (int t = 0; t < LIMIT && !ready_seen; t++) begin
      @(posedge clk);
      #1;
      ready_seen = s_gfx_ready;
    end
    if (!ready_seen) begin
      errors++;
      $display("s_gfx_ready did not rise after reset");
    end
    check_count("awvalid after reset", 8'd0, 8'(m_axi_awvalid));
    check_count("wvalid after reset", 8'd0, 8'(m_axi_wvalid));
    check_count("bready after reset", 8'd1, 8'(m_axi_bready));
    for (int r = 0; r < N_ROWS; r++) begin
      // The visible area only changes once the pipeline has drained.
      if (rows[r].h != h_visible || rows[r].v != v_visible) begin
        wait_writes(n_in, 0);
        h_visible = rows[r].h;
        v_visible = rows[r].v;
      end
      send_pixel(r);
      n_in += row_in[r];
    end
    wait_writes(n_in, n_in);
    repeat (20) @(posedge clk);
    #1;
    if (aw_count != n_in || w_count != n_in || b_count != n_in) begin
      errors++;
      $display("Write count mismatch, expected %0d of each", n_in);
    end
    check_count("err_count", 8'(n_err), err_count);
    $display("checks=%0d errors=%0d aw=%0d w=%0d b=%0d",
             checks, errors, aw_count, w_count, b_count);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
gfx_fb_pkg.sv
gfx_fb_fifo.sv
gfx_fb_addr.sv
gfx_fb_axi_wr.sv
gfx_fb.sv
gfx_fb_tb.sv

// ==== Bender.yml ====
package:
  name: gfx_fb

sources:
  - gfx_fb_pkg.sv
  - gfx_fb_fifo.sv
  - gfx_fb_addr.sv
  - gfx_fb_axi_wr.sv
  - gfx_fb.sv
  - target: test
    files:
      - gfx_fb_tb.sv
